//--- hdl/fetch_pkg.sv
package fetch_pkg;

    localparam int PC_W   = 32;
    localparam int INST_W = 32;
    localparam int EXC_W  = 5;

    typedef logic [PC_W-1:0]   pc_t;
    typedef logic [INST_W-1:0] inst_t;
    typedef logic [EXC_W-1:0]  exc_code_t;

    // exception codes as reported to decode
    localparam exc_code_t exc_none = 5'd0;
    localparam exc_code_t exc_adel = 5'd4;  // address error on instruction fetch

    localparam pc_t RESET_PC      = 32'hbfc0_0000;
    localparam pc_t GENERAL_EX_PC = 32'hbfc0_0380;
    localparam pc_t KUSEG_OFFSET  = 32'h2000_0000;  // user segment physical base

    // one in-order fetch slot, pushed when the request leaves pre-fetch
    typedef struct packed {
        pc_t       pc;
        logic      ex;
        exc_code_t exc;
    } fetch_entry_t;

    // next slot of a ring buffer with any depth
    function automatic int unsigned ring_next(input int unsigned ptr,
                                              input int unsigned depth);
        int unsigned nxt;
        nxt = ptr + 1;
        if (nxt >= depth) begin
            nxt = 0;
        end
        return nxt;
    endfunction

endpackage

//--- hdl/fetch_req_if.sv
`timescale 1ns/1ns

// pre-fetch to fetch queue, one entry per issued fetch
interface fetch_req_if
    import fetch_pkg::*;
();
    logic         push;   // write entry this edge
    fetch_entry_t entry;
    logic         full;
    logic         clear;  // redirect, kill everything queued

    modport producer (
        output push,
        output entry,
        output clear,
        input  full
    );

    modport buffer (
        input  push,
        input  entry,
        input  clear,
        output full
    );

endinterface

//--- hdl/itlb_map.sv
`timescale 1ns/1ns

module itlb_map
    import fetch_pkg::*;
(
    input  logic [19:0] vpn,
    output logic [19:0] pfn
);

    // fixed segment map, no real TLB behind it
    always_comb begin
        if (vpn[19:18] == 2'b10) begin
            pfn = {3'b000, vpn[16:0]};          // kseg0 / kseg1 unmapped
        end else begin
            pfn = vpn + KUSEG_OFFSET[31:12];    // kuseg and kseg2/3
        end
    end

endmodule

//--- hdl/pre_if_stage.sv
`timescale 1ns/1ns

module pre_if_stage
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        eret,
    input  pc_t         epc,
    input  logic        br_valid,
    input  logic        br_predicted,
    input  logic        br_pred_right,
    input  logic        br_taken,
    input  pc_t         br_target,
    input  pc_t         br_pc,
    input  logic        bpu_valid,
    input  pc_t         bpu_target,
    input  logic        icache_busy,
    output logic        inst_req,
    output logic [7:0]  inst_index,
    output logic [19:0] inst_tag,
    output logic [3:0]  inst_offset,
    fetch_req_if.producer req
);

    pc_t         pc;
    pc_t         next_pc;
    pc_t         seq_pc;
    pc_t         flow_pc;
    logic        mispredict;
    logic        unpred_taken;
    logic        redirect;
    logic        misaligned;
    logic        push;
    logic        run;       // low for the first cycle out of reset
    logic [19:0] pfn;

    assign seq_pc       = pc + 32'd4;
    assign flow_pc      = bpu_valid ? bpu_target : seq_pc;
    assign mispredict   = br_valid & br_predicted & ~br_pred_right;
    assign unpred_taken = br_valid & ~br_predicted & br_taken;
    assign redirect     = eret | flush | mispredict | unpred_taken;

    always_comb begin
        if (eret) begin
            next_pc = epc;
        end else if (flush) begin
            next_pc = GENERAL_EX_PC;
        end else if (mispredict) begin
            // delay slot already out, so fall-through skips it
            next_pc = br_taken ? br_target : br_pc + 32'd8;
        end else if (unpred_taken) begin
            next_pc = br_target;
        end else begin
            next_pc = flow_pc;
        end
    end

    assign misaligned = pc[1:0] != 2'b00;

    // a bad pc never goes to the cache, so busy does not hold it back
    assign push     = run & ~redirect & ~req.full & (misaligned | ~icache_busy);
    assign inst_req = push & ~misaligned;

    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect || push) begin
            pc <= next_pc;
        end
    end

    assign req.push      = push;
    assign req.clear     = redirect;
    assign req.entry.pc  = pc;
    assign req.entry.ex  = misaligned;
    assign req.entry.exc = misaligned ? exc_adel : exc_none;

    itlb_map u_itlb (
        .vpn (pc[31:12]),
        .pfn (pfn)
    );

    assign inst_tag    = pfn;
    assign inst_index  = pc[11:4];
    assign inst_offset = pc[3:0];

endmodule

//--- hdl/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue
    import fetch_pkg::*;
#(
    parameter int  QUEUE_DEPTH = 4,
    parameter type entry_t     = fetch_entry_t
) (
    input  logic   clk,
    input  logic   reset,
    fetch_req_if.buffer req,
    output logic   valid,
    output entry_t head,
    input  logic   pop
);

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    entry_t        mem [QUEUE_DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] wr_slot;
    logic [CW-1:0] count;
    logic          do_pop;

    assign do_pop  = pop & valid;
    assign wr_slot = req.clear ? '0 : wr_ptr;  // redirect's first entry goes to slot 0

    always_ff @(posedge clk) begin
        if (req.push) begin
            mem[wr_slot] <= req.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (req.clear) begin
            rd_ptr <= '0;
            wr_ptr <= req.push ? PW'(ring_next(0, QUEUE_DEPTH)) : '0;
            count  <= CW'(req.push);
        end else begin
            if (req.push) begin
                wr_ptr <= PW'(ring_next(wr_ptr, QUEUE_DEPTH));
            end
            if (do_pop) begin
                rd_ptr <= PW'(ring_next(rd_ptr, QUEUE_DEPTH));
            end
            count <= count + CW'(req.push) - CW'(do_pop);
        end
    end

    assign valid    = count != '0;
    assign req.full = count == CW'(QUEUE_DEPTH);
    assign head     = mem[rd_ptr];

endmodule

//--- hdl/if_stage.sv
`timescale 1ns/1ns

module if_stage
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         valid,
    input  fetch_entry_t head,
    input  logic         clear,
    output logic         pop,
    input  logic         inst_req,
    input  logic         inst_rvalid,
    input  inst_t        inst_rdata,
    input  logic         ds_allowin,
    output logic         ds_valid,
    output pc_t          ds_pc,
    output inst_t        ds_inst,
    output logic         ds_ex,
    output exc_code_t    ds_exc
);

    localparam int CW = $clog2(2 * QUEUE_DEPTH + 1);  // live plus killed in flight
    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int BW = $clog2(QUEUE_DEPTH + 1);

    logic [CW-1:0] out_cnt;
    logic [CW-1:0] discard_cnt;
    logic          drop;
    logic          live_rsp;
    inst_t         rsp_buf [QUEUE_DEPTH];  // words that beat their entry to the head
    logic [PW-1:0] buf_rd;
    logic [PW-1:0] buf_wr;
    logic [BW-1:0] buf_cnt;
    logic          buf_avail;
    logic          buf_push;
    logic          buf_pop;
    logic          load;
    logic          load_word;
    inst_t         load_data;

    assign drop      = inst_rvalid & (clear | (discard_cnt != '0));
    assign live_rsp  = inst_rvalid & ~drop;
    assign buf_avail = buf_cnt != '0;

    // output register refills one cycle after the previous pop
    assign load      = valid & ~ds_valid & ~clear & (head.ex | buf_avail | live_rsp);
    assign load_word = load & ~head.ex;
    assign buf_pop   = load_word & buf_avail;
    assign buf_push  = live_rsp & ~(load_word & ~buf_avail);  // unless it bypasses
    assign load_data = buf_avail ? rsp_buf[buf_rd] : inst_rdata;
    assign pop       = ds_valid & ds_allowin;

    // no request goes out on a clear cycle, so out_cnt here is all stale
    always_ff @(posedge clk) begin
        if (reset) begin
            out_cnt     <= '0;
            discard_cnt <= '0;
        end else begin
            out_cnt <= out_cnt + CW'(inst_req) - CW'(inst_rvalid);
            if (clear) begin
                discard_cnt <= out_cnt - CW'(inst_rvalid);
            end else if (drop) begin
                discard_cnt <= discard_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            buf_rd  <= '0;
            buf_wr  <= '0;
            buf_cnt <= '0;
        end else begin
            if (buf_push) begin
                buf_wr <= PW'(ring_next(buf_wr, QUEUE_DEPTH));
            end
            if (buf_pop) begin
                buf_rd <= PW'(ring_next(buf_rd, QUEUE_DEPTH));
            end
            buf_cnt <= buf_cnt + BW'(buf_push) - BW'(buf_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (buf_push) begin
            rsp_buf[buf_wr] <= inst_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            ds_valid <= 1'b0;
        end else if (load) begin
            ds_valid <= 1'b1;
        end else if (pop) begin
            ds_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ds_pc   <= head.pc;
            ds_ex   <= head.ex;
            ds_exc  <= head.exc;
            ds_inst <= head.ex ? '0 : load_data;  // bad fetch carries no word
        end
    end

endmodule

//--- hdl/fetch_frontend.sv
`timescale 1ns/1ns

module fetch_frontend
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        eret,
    input  pc_t         epc,
    input  logic        br_valid,
    input  logic        br_predicted,
    input  logic        br_pred_right,
    input  logic        br_taken,
    input  pc_t         br_target,
    input  pc_t         br_pc,
    input  logic        bpu_valid,
    input  pc_t         bpu_target,
    output logic        inst_req,
    output logic [7:0]  inst_index,
    output logic [19:0] inst_tag,
    output logic [3:0]  inst_offset,
    input  logic        icache_busy,
    input  logic        inst_rvalid,
    input  inst_t       inst_rdata,
    output logic        ds_valid,
    output pc_t         ds_pc,
    output inst_t       ds_inst,
    output logic        ds_ex,
    output exc_code_t   ds_exc,
    input  logic        ds_allowin
);

    fetch_req_if req_bus ();

    logic         q_valid;
    fetch_entry_t q_head;
    logic         q_pop;

    pre_if_stage u_pre_if (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .eret          (eret),
        .epc           (epc),
        .br_valid      (br_valid),
        .br_predicted  (br_predicted),
        .br_pred_right (br_pred_right),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .br_pc         (br_pc),
        .bpu_valid     (bpu_valid),
        .bpu_target    (bpu_target),
        .icache_busy   (icache_busy),
        .inst_req      (inst_req),
        .inst_index    (inst_index),
        .inst_tag      (inst_tag),
        .inst_offset   (inst_offset),
        .req           (req_bus.producer)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .entry_t     (fetch_entry_t)
    ) u_queue (
        .clk   (clk),
        .reset (reset),
        .req   (req_bus.buffer),
        .valid (q_valid),
        .head  (q_head),
        .pop   (q_pop)
    );

    if_stage #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_if (
        .clk         (clk),
        .reset       (reset),
        .valid       (q_valid),
        .head        (q_head),
        .clear       (req_bus.clear),
        .pop         (q_pop),
        .inst_req    (inst_req),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .ds_allowin  (ds_allowin),
        .ds_valid    (ds_valid),
        .ds_pc       (ds_pc),
        .ds_inst     (ds_inst),
        .ds_ex       (ds_ex),
        .ds_exc      (ds_exc)
    );

endmodule

//--- test/tb_fetch_frontend.sv
`timescale 1ns/1ns

module tb_fetch_frontend
    import fetch_pkg::*;
();

    localparam int    QUEUE_DEPTH = 4;
    localparam inst_t DATA_KEY    = 32'h3c5a_96e1;  // cache data is word address ^ key

    logic        clk;
    logic        reset;
    logic        flush;
    logic        eret;
    pc_t         epc;
    logic        br_valid;
    logic        br_predicted;
    logic        br_pred_right;
    logic        br_taken;
    pc_t         br_target;
    pc_t         br_pc;
    logic        bpu_valid;
    pc_t         bpu_target;
    logic        inst_req;
    logic [7:0]  inst_index;
    logic [19:0] inst_tag;
    logic [3:0]  inst_offset;
    logic        icache_busy;
    logic        inst_rvalid;
    inst_t       inst_rdata;
    logic        ds_valid;
    pc_t         ds_pc;
    inst_t       ds_inst;
    logic        ds_ex;
    exc_code_t   ds_exc;
    logic        ds_allowin;

    typedef enum logic [3:0] {
        ev_run, ev_predict, ev_mispredict_taken, ev_mispredict_fall, ev_unpredicted_taken,
        ev_flush, ev_eret, ev_misalign_target, ev_stall_decode
    } ev_kind_t;

    // a is br_pc / epc / words ahead, b is the branch or prediction target
    typedef struct packed {
        ev_kind_t    kind;
        int unsigned wait_cnt;
        pc_t         a;
        pc_t         b;
    } stim_row_t;

    typedef struct packed {
        pc_t paddr;
        int  due;
    } cache_req_t;

    stim_row_t  rows [$];
    cache_req_t cache_q [$];    // requests waiting for their response
    int         cyc;
    int         cycle_limit;
    int         delivered;
    int         live_out;       // requests since the last redirect still unanswered
    int         stale_left;     // killed requests still in flight
    int         stall_left;
    pc_t        exp_pc;
    pc_t        pred_pc;
    pc_t        pred_target;
    pc_t        redir_target;
    logic       pred_armed;
    logic       redir_pending;

    fetch_frontend #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fixed segment map with kseg0/kseg1 dropping the top bits
    function automatic pc_t phys_addr(input pc_t va);
        if (va[31:30] == 2'b10) begin
            return {3'b000, va[28:0]};
        end
        return va + KUSEG_OFFSET;
    endfunction

    function automatic inst_t model_word(input pc_t pa);
        return {2'b00, pa[31:2]} ^ DATA_KEY;
    endfunction

    function automatic pc_t cache_addr();
        return {inst_tag, inst_index, inst_offset};
    endfunction

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_inst(input string name, input inst_t expected, input inst_t actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_exc(input string name, input exc_code_t expected,
                             input exc_code_t actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, expected, actual);
            stop_run();
        end
    endtask

    // one clock of cache model, busy, decode stall and predictor, 1 ns after the edge
    task automatic advance_cycle();
        @(posedge clk);
        #1;
        cyc++;
        if (cyc > cycle_limit) begin
            $display("timeout: fetches stopped arriving within %0d cycles", cycle_limit);
            stop_run();
        end
        flush    = 1'b0;  // redirects are single-cycle pulses
        eret     = 1'b0;
        br_valid = 1'b0;
        inst_rvalid = 1'b0;
        if (cache_q.size() != 0 && cache_q[0].due <= cyc) begin
            inst_rvalid = 1'b1;
            inst_rdata  = model_word(cache_q[0].paddr);
            void'(cache_q.pop_front());
            if (stale_left > 0) begin
                stale_left--;
            end else begin
                live_out--;
            end
        end
        icache_busy = ($urandom_range(4, 0) == 0);
        if (stall_left > 0) begin
            ds_allowin = 1'b0;
            stall_left--;
        end else begin
            ds_allowin = ($urandom_range(9, 0) != 0);
        end
        bpu_valid  = pred_armed && (cache_addr() == phys_addr(pred_pc));
        bpu_target = pred_target;
    endtask

    task automatic wait_fetches(input int unsigned n);
        int target;
        target = delivered + int'(n);
        do begin
            advance_cycle();
        end while (delivered < target);
    endtask

    task automatic add_row(input ev_kind_t kind, input int unsigned wait_cnt,
                           input pc_t a, input pc_t b);
        stim_row_t row;
        row.kind     = kind;
        row.wait_cnt = wait_cnt;
        row.a        = a;
        row.b        = b;
        rows.push_back(row);
    endtask

    task automatic redirect_to(input pc_t target);
        redir_target  = target;
        redir_pending = 1'b1;
    endtask

    task automatic apply_row(input stim_row_t row);
        case (row.kind)
            ev_predict: begin
                pred_pc     = exp_pc + (row.a << 2);  // far enough ahead of pre-fetch
                pred_target = row.b;
                pred_armed  = 1'b1;
            end
            ev_mispredict_taken, ev_mispredict_fall: begin
                br_valid      = 1'b1;
                br_predicted  = 1'b1;
                br_pred_right = 1'b0;
                br_taken      = (row.kind == ev_mispredict_taken);
                br_pc         = row.a;
                br_target     = row.b;
                redirect_to(br_taken ? row.b : row.a + 32'd8);  // delay slot already out
            end
            ev_unpredicted_taken, ev_misalign_target: begin
                br_valid     = 1'b1;
                br_predicted = 1'b0;
                br_taken     = 1'b1;
                br_target    = row.b;
                redirect_to(row.b);
            end
            ev_flush: begin
                flush = 1'b1;
                redirect_to(GENERAL_EX_PC);
            end
            ev_eret: begin
                eret  = 1'b1;
                flush = 1'b1;  // eret wins
                epc   = row.a;
                redirect_to(row.a);
            end
            ev_stall_decode: stall_left = int'($urandom_range(24, 8));
            default: ;
        endcase
    endtask

    // sample at the falling edge, where every input and output is settled
    always @(negedge clk) begin
        cache_req_t r;
        logic       bad;
        if (!reset) begin
            if (inst_req) begin
                if (inst_offset[1:0] != 2'b00) begin
                    $display("cache request issued for a misaligned fetch at t=%0t", $time);
                    stop_run();
                end
                r.paddr = cache_addr();
                r.due   = cyc + int'($urandom_range(3, 1));
                cache_q.push_back(r);
                live_out++;
                if (live_out > QUEUE_DEPTH) begin
                    $display("more than %0d live cache requests at t=%0t", QUEUE_DEPTH, $time);
                    stop_run();
                end
            end
            if (ds_valid && ds_allowin) begin  // handshake on the coming edge
                bad = exp_pc[1:0] != 2'b00;
                check_pc("ds_pc", exp_pc, ds_pc);
                check_flag("ds_ex", bad, ds_ex);
                check_exc("ds_exc", bad ? exc_adel : exc_none, ds_exc);
                check_inst("ds_inst", bad ? '0 : model_word(phys_addr(exp_pc)), ds_inst);
                if (pred_armed && exp_pc == pred_pc) begin
                    exp_pc     = pred_target;
                    pred_armed = 1'b0;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
                delivered++;
            end
            if (redir_pending) begin  // everything undelivered is killed
                exp_pc        = redir_target;
                redir_pending = 1'b0;
                stale_left    = cache_q.size();
                live_out      = 0;
            end
        end
    end

    initial begin
        int total;
        void'($urandom(32'h525bba69));
        reset = 1'b1;
        flush = 1'b0;
        eret = 1'b0;
        epc = '0;
        br_valid = 1'b0;
        br_predicted = 1'b0;
        br_pred_right = 1'b0;
        br_taken = 1'b0;
        br_target = '0;
        br_pc = '0;
        bpu_valid = 1'b0;
        bpu_target = '0;
        icache_busy = 1'b0;
        inst_rvalid = 1'b0;
        inst_rdata = '0;
        ds_allowin = 1'b1;
        cyc = 0;
        delivered = 0;
        live_out = 0;
        stale_left = 0;
        stall_left = 0;
        exp_pc = RESET_PC;
        pred_pc = '0;
        pred_target = '0;
        redir_target = '0;
        pred_armed = 1'b0;
        redir_pending = 1'b0;

        add_row(ev_run,               10, '0,            '0);
        add_row(ev_predict,            2, 32'd8,         32'hbfc0_0800);
        add_row(ev_run,               14, '0,            '0);
        add_row(ev_mispredict_taken,   0, 32'hbfc0_0a00, 32'hbfc0_1000);
        add_row(ev_mispredict_fall,    6, 32'hbfc0_2000, 32'hbfc0_2800);
        add_row(ev_unpredicted_taken,  6, '0,            32'h8000_3000);
        add_row(ev_stall_decode,       5, '0,            '0);
        add_row(ev_flush,              8, '0,            '0);
        add_row(ev_eret,               6, 32'h0040_0100, '0);
        add_row(ev_misalign_target,    5, '0,            32'hbfc0_4002);
        add_row(ev_flush,              3, '0,            '0);
        add_row(ev_stall_decode,       4, '0,            '0);
        add_row(ev_predict,            2, 32'd6,         32'hbfc0_5000);
        add_row(ev_stall_decode,       8, '0,            '0);
        add_row(ev_mispredict_taken,  10, 32'hbfc0_5100, 32'hbfc0_6000);
        add_row(ev_stall_decode,       3, '0,            '0);
        add_row(ev_run,               20, '0,            '0);

        total = 0;
        foreach (rows[i]) begin
            total += int'(rows[i].wait_cnt);
        end
        cycle_limit = total * 12 + 200;

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        foreach (rows[i]) begin
            wait_fetches(rows[i].wait_cnt);
            apply_row(rows[i]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- tb.f
hdl/fetch_pkg.sv
hdl/fetch_req_if.sv
hdl/itlb_map.sv
hdl/pre_if_stage.sv
hdl/fetch_queue.sv
hdl/if_stage.sv
hdl/fetch_frontend.sv
test/tb_fetch_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front-end testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing -f tb.f --top-module tb_fetch_frontend \
        -Mdir "$BUILD_DIR" -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

if ! "./$BUILD_DIR/sim_tb" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi
cat "$LOG"

if grep -qx "TB PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
